// ==== hdl/fe_pkg.sv ====
package fe_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int WORD_SIZE_P = 16;
  localparam int REG_ID_W    = 4;

  // Opcode field, bits 15:12 of an instruction
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_ADDI = 4'd2,
    OP_LDI  = 4'd3,
    OP_BRA  = 4'd8,
    OP_BCC  = 4'd9
  } opcode_e;

  // Unit that executes a decoded instruction in the back end
  typedef enum logic [1:0] {
    FU_NOOP,
    FU_ALU,
    FU_BRANCH
  } fu_e;

  // Fetch/decode payload
  typedef struct packed {
    logic [WORD_SIZE_P-1:0] pc;
    logic [WORD_SIZE_P-1:0] instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic [WORD_SIZE_P-1:0] pc;
    fu_e                    fu;
    opcode_e                opcode;
    logic                   w_v;
    logic [REG_ID_W-1:0]    dest_id;
    logic [REG_ID_W-1:0]    source_1;
    logic [REG_ID_W-1:0]    source_2;
    logic [3:0]             bcc_op;
    logic [WORD_SIZE_P-1:0] imm;
    logic                   branch_speculation;
  } decoded_instruction_t;

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit
  import fe_pkg::*;
  #(parameter logic [WORD_SIZE_P-1:0] RESET_PC_P = '0
  )
  ( input  logic                   clk_i
  , input  logic                   rst_n_i
  , input  logic                   advance_i
  , input  logic                   take_branch_i
  , input  logic [WORD_SIZE_P-1:0] branch_target_i
  , input  logic                   mis_predict_i
  , input  logic [WORD_SIZE_P-1:0] mis_target_i
  , output logic [WORD_SIZE_P-1:0] pc_o
  );

  logic [WORD_SIZE_P-1:0] pc_r;
  logic [WORD_SIZE_P-1:0] pc_inc;
  logic [WORD_SIZE_P-1:0] pc_n;

  // Word addressed, so the sequential step is one
  assign pc_inc = pc_r + 1'b1;

  // Mis-predict ignores the stall, a taken branch does not
  always_comb begin
    pc_n = pc_r;
    if (mis_predict_i) begin
      pc_n = mis_target_i;
    end else if (advance_i) begin
      pc_n = take_branch_i ? branch_target_i : pc_inc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_r <= RESET_PC_P;
    end else begin
      pc_r <= pc_n;
    end
  end

  assign pc_o = pc_r;

endmodule

// ==== hdl/pipe_stage.sv ====
`timescale 1ns/1ns

module pipe_stage
  #(parameter type payload_t = logic
  )
  ( input  logic     clk_i
  , input  logic     rst_n_i
  , input  logic     advance_i
  , input  logic     flush_i
  , input  logic     v_i
  , input  payload_t data_i
  , output logic     v_o
  , output payload_t data_o
  );

  logic     v_r;
  payload_t data_r;

  // Flush acts even while the stage is stalled
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      v_r <= 1'b0;
    end else if (advance_i) begin
      v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      data_r <= data_i;
    end
  end

  assign v_o    = v_r;
  assign data_o = data_r;

endmodule

// ==== hdl/decoder.sv ====
`timescale 1ns/1ns

module decoder
  import fe_pkg::*;
  ( input  fetch_pkt_t           instr_i
  , output decoded_instruction_t dec_o
  );

  logic [WORD_SIZE_P-1:0] instr;
  logic [3:0]             op_field;
  logic [REG_ID_W-1:0]    rd_field;
  logic [REG_ID_W-1:0]    rs1_field;
  logic [REG_ID_W-1:0]    rs2_field;
  logic [WORD_SIZE_P-1:0] imm4_sext;
  logic [WORD_SIZE_P-1:0] imm8_sext;
  logic [WORD_SIZE_P-1:0] imm8_zext;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign instr     = instr_i.instr;
  assign op_field  = instr[15:12];
  assign rd_field  = instr[11:8];
  assign rs1_field = instr[7:4];
  assign rs2_field = instr[3:0];

  // Immediate extension
  assign imm4_sext = {{(WORD_SIZE_P-4){instr[3]}}, instr[3:0]};
  assign imm8_sext = {{(WORD_SIZE_P-8){instr[7]}}, instr[7:0]};
  assign imm8_zext = {{(WORD_SIZE_P-8){1'b0}}, instr[7:0]};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Opcode decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    // Anything not named below stays zero
    dec_o        = '0;
    dec_o.pc     = instr_i.pc;
    dec_o.fu     = FU_NOOP;
    dec_o.opcode = OP_NOP;
    case (op_field)
      OP_ADD: begin
        dec_o.fu       = FU_ALU;
        dec_o.opcode   = OP_ADD;
        dec_o.w_v      = 1'b1;
        dec_o.dest_id  = rd_field;
        dec_o.source_1 = rs1_field;
        dec_o.source_2 = rs2_field;
      end
      OP_ADDI: begin
        dec_o.fu       = FU_ALU;
        dec_o.opcode   = OP_ADDI;
        dec_o.w_v      = 1'b1;
        dec_o.dest_id  = rd_field;
        dec_o.source_1 = rs1_field;
        dec_o.imm      = imm4_sext;
      end
      OP_LDI: begin
        dec_o.fu      = FU_ALU;
        dec_o.opcode  = OP_LDI;
        dec_o.w_v     = 1'b1;
        dec_o.dest_id = rd_field;
        dec_o.imm     = imm8_zext;
      end
      OP_BRA: begin
        dec_o.fu     = FU_BRANCH;
        dec_o.opcode = OP_BRA;
        dec_o.imm    = imm8_sext;
      end
      OP_BCC: begin
        dec_o.fu     = FU_BRANCH;
        dec_o.opcode = OP_BCC;
        dec_o.bcc_op = rd_field;
        dec_o.imm    = imm8_sext;
      end
      // Undefined opcodes fall through as no-ops
      default: ;
    endcase
  end

endmodule

// ==== hdl/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit
  import fe_pkg::*;
  ( input  logic                   v_i
  , input  decoded_instruction_t   dec_i
  , input  logic                   advance_i
  , input  logic                   mis_predict_i
  , output logic                   take_branch_o
  , output logic [WORD_SIZE_P-1:0] branch_target_o
  , output logic                   flush_o
  , output decoded_instruction_t   dec_o
  , output logic                   valid_o
  );

  logic is_bra;
  logic is_bcc;
  logic backward;
  logic predict_taken;

  assign is_bra   = (dec_i.opcode == OP_BRA);
  assign is_bcc   = (dec_i.opcode == OP_BCC);
  assign backward = dec_i.imm[WORD_SIZE_P-1];

  // Static prediction
  // BRA always, BCC only when it jumps backward
  assign predict_taken = is_bra | (is_bcc & backward);

  // Redirect only when the stage really moves on
  assign take_branch_o   = v_i & predict_taken & advance_i;
  assign branch_target_o = dec_i.pc + dec_i.imm;

  // Both younger stages are squashed on either redirect
  assign flush_o = take_branch_o | mis_predict_i;

  always_comb begin
    dec_o                    = dec_i;
    dec_o.branch_speculation = is_bcc & backward;
  end

  // No-ops and BRA need nothing from the back end
  assign valid_o = v_i & (dec_i.fu != FU_NOOP) & ~is_bra;

endmodule

// ==== hdl/fe_top.sv ====
`timescale 1ns/1ns

module fe_top
  import fe_pkg::*;
  #(parameter logic [WORD_SIZE_P-1:0] RESET_PC_P = '0
  )
  ( input  logic                   clk_i
  , input  logic                   rst_n_i
  , input  logic                   ready_i
  , input  logic                   mis_predict_i
  , input  logic [WORD_SIZE_P-1:0] branch_mis_target_i
  , output logic [WORD_SIZE_P-1:0] imem_addr_o
  , input  logic [WORD_SIZE_P-1:0] imem_data_i
  , output decoded_instruction_t   dec_instr_o
  , output logic                   valid_o
  );

  logic                   advance;
  logic                   take_branch;
  logic                   flush;
  logic [WORD_SIZE_P-1:0] branch_target;
  logic [WORD_SIZE_P-1:0] pc;

  // The whole front end moves only when the back end is ready
  assign advance = ready_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fetch_unit #(.RESET_PC_P(RESET_PC_P)
    ) u_fetch
    ( .clk_i
    , .rst_n_i
    , .advance_i       (advance)
    , .take_branch_i   (take_branch)
    , .branch_target_i (branch_target)
    , .mis_predict_i
    , .mis_target_i    (branch_mis_target_i)
    , .pc_o            (pc)
    );

  assign imem_addr_o = pc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch/decode stage and decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fetch_pkt_t fetch_pkt;
  fetch_pkt_t fd_pkt;
  logic       fd_v;

  assign fetch_pkt = '{pc: pc, instr: imem_data_i};

  // Free-running fetch, every cycle offers a word
  pipe_stage #(.payload_t(fetch_pkt_t)
    ) u_fd
    ( .clk_i
    , .rst_n_i
    , .advance_i (advance)
    , .flush_i   (flush)
    , .v_i       (1'b1)
    , .data_i    (fetch_pkt)
    , .v_o       (fd_v)
    , .data_o    (fd_pkt)
    );

  decoded_instruction_t dec_d;

  decoder u_decoder
    ( .instr_i (fd_pkt)
    , .dec_o   (dec_d)
    );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode/branch stage and branch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  decoded_instruction_t db_dec;
  logic                 db_v;

  pipe_stage #(.payload_t(decoded_instruction_t)
    ) u_db
    ( .clk_i
    , .rst_n_i
    , .advance_i (advance)
    , .flush_i   (flush)
    , .v_i       (fd_v)
    , .data_i    (dec_d)
    , .v_o       (db_v)
    , .data_o    (db_dec)
    );

  branch_unit u_branch
    ( .v_i             (db_v)
    , .dec_i           (db_dec)
    , .advance_i       (advance)
    , .mis_predict_i
    , .take_branch_o   (take_branch)
    , .branch_target_o (branch_target)
    , .flush_o         (flush)
    , .dec_o           (dec_instr_o)
    , .valid_o
    );

endmodule

// ==== testbench/fe_chk.sv ====
`timescale 1ns/1ns

module fe_chk
  import fe_pkg::*;
  ( input logic                   clk_i
  , input logic                   rst_n_i
  , input logic                   ready_i
  , input logic                   mis_predict_i
  , input logic [WORD_SIZE_P-1:0] imem_addr_i
  , input decoded_instruction_t   dec_instr_i
  , input logic                   valid_i
  );

  int violations = 0;

  valid_low_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !valid_i)
    else begin
      violations++;
      $error("valid_o is high in the cycle after reset");
    end

  // Only ALU work and BCC reach the back end, on the unit their opcode names
  no_nop_output: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_i |-> dec_instr_i.opcode != OP_NOP
        && dec_instr_i.fu == (dec_instr_i.opcode == OP_BCC ? FU_BRANCH : FU_ALU))
    else begin
      violations++;
      $error("valid_o is high for a no-op or on the wrong unit");
    end

  // A stall without a redirect freezes every output
  hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rst_n_i && !ready_i && !mis_predict_i
      |=> $stable(valid_i) && $stable(imem_addr_i) && (!valid_i || $stable(dec_instr_i)))
    else begin
      violations++;
      $error("outputs changed while ready_i was low");
    end

endmodule

bind fe_top fe_chk u_fe_chk
  ( .clk_i
  , .rst_n_i
  , .ready_i
  , .mis_predict_i
  , .imem_addr_i (imem_addr_o)
  , .dec_instr_i (dec_instr_o)
  , .valid_i     (valid_o)
  );

// ==== testbench/fe_tb.sv ====
`timescale 1ns/1ns

module fe_tb;
  import fe_pkg::*;

  localparam int MAX_CYCLES  = 200;
  localparam int WATCHDOG_NS = 6 * MAX_CYCLES * 2 * 20;

  // Twelve words per program, index 0 sits at the load address
  typedef logic [0:11][WORD_SIZE_P-1:0] prog_t;

  // LDI, ADDI -3, ADDI +7, ADD, LDI 0xF0, ADD
  localparam prog_t STRAIGHT = {16'h315A, 16'h221D, 16'h2327, 16'h1413, 16'h35F0, 16'h1645,
                                {6{16'hF000}}};
  // NOP and undefined opcodes between ALU words
  localparam prog_t DROPS = {16'h3101, 16'h0000, 16'h3202, 16'h5123, 16'h0FFF, 16'h1312,
                             16'hA000, 16'h7777, 16'h2431, {3{16'hF000}}};
  // BRA +3 at word 1 skips words 2 and 3
  localparam prog_t UNCOND = {16'h3101, 16'h8003, 16'h3202, 16'h3303, 16'h1412, 16'h3505,
                              {6{16'hF000}}};
  // Backward BCC at word 4 returns to word 2; forward BCC at word 7 falls through
  localparam prog_t COND = {16'h3105, 16'h8003, 16'h2211, 16'h8004, 16'h93FE, 16'h3505,
                            16'h3606, 16'h9503, 16'h1712, 16'h3808, {2{16'hF000}}};

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   ready_i;
  logic                   mis_predict_i;
  logic [WORD_SIZE_P-1:0] branch_mis_target_i;
  logic [WORD_SIZE_P-1:0] imem_addr_o;
  logic [WORD_SIZE_P-1:0] imem_data_i;
  decoded_instruction_t   dec_instr_o;
  logic                   valid_o;

  logic [WORD_SIZE_P-1:0] imem [256];
  decoded_instruction_t   exp_q [$];
  logic [31:0]            lfsr;
  int                     accepted;
  int                     errors;
  int                     passes;
  int                     fails;

  fe_top u_fe_top (.*);

  assign imem_data_i = imem[imem_addr_o[7:0]];

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic decoded_instruction_t ref_decode(input logic [15:0] pc,
                                                      input logic [15:0] w);
    decoded_instruction_t d;
    logic [3:0]           op;
    logic                 alu;
    logic                 br;
    op         = w[15:12];
    alu        = (op == 4'd1) || (op == 4'd2) || (op == 4'd3);
    br         = (op == 4'd8) || (op == 4'd9);
    d          = '0;
    d.pc       = pc;
    d.fu       = alu ? FU_ALU : (br ? FU_BRANCH : FU_NOOP);
    d.opcode   = (alu || br) ? opcode_e'(op) : OP_NOP;
    d.w_v      = alu;
    d.dest_id  = alu ? w[11:8] : 4'd0;
    d.source_1 = (op == 4'd1 || op == 4'd2) ? w[7:4] : 4'd0;
    d.source_2 = (op == 4'd1) ? w[3:0] : 4'd0;
    d.bcc_op   = (op == 4'd9) ? w[11:8] : 4'd0;
    if (op == 4'd2) begin
      d.imm = {{12{w[3]}}, w[3:0]};
    end else if (op == 4'd3) begin
      d.imm = {8'h00, w[7:0]};
    end else if (br) begin
      d.imm = {{8{w[7]}}, w[7:0]};
    end
    return d;
  endfunction

  // Follow the program with static prediction and queue what the back end sees
  task automatic walk(input logic [15:0] start, input logic [15:0] stop, input int max_out);
    logic [15:0]          pc;
    decoded_instruction_t d;
    pc = start;
    for (int s = 0; s < 64 && pc < stop && exp_q.size() < max_out; s++) begin
      d = ref_decode(pc, imem[pc[7:0]]);
      d.branch_speculation = (d.opcode == OP_BCC) && d.imm[15];
      if (d.fu != FU_NOOP && d.opcode != OP_BRA) begin
        exp_q.push_back(d);
      end
      pc = (d.opcode == OP_BRA || d.branch_speculation) ? pc + d.imm : pc + 16'd1;
    end
  endtask

  task automatic load_program(input logic [15:0] base, input prog_t prog);
    for (int i = 0; i < 12; i++) begin
      imem[base + i] = prog[i];
    end
  endtask

  // Fill with opcode F, which decodes as a no-op
  task automatic prepare(input prog_t prog, input int max_out);
    exp_q.delete();
    for (int a = 0; a < 256; a++) begin
      imem[a] = {8'hF0, a[7:0]};
    end
    load_program(16'h0000, prog);
    walk(16'h0000, 16'd12, max_out);
  endtask

  task automatic check_decoded(input string sig, input decoded_instruction_t exp,
                               input decoded_instruction_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, sig, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, sig, exp, act);
      errors++;
    end
  endtask

  // Falling edge, where outputs and edge-driven inputs have settled
  always @(negedge clk_i) begin
    if (rst_n_i && valid_o && ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Extra output at %0t from pc %h", $time, dec_instr_o.pc);
        errors++;
      end else begin
        check_bit("dec_instr_o.branch_speculation", exp_q[0].branch_speculation,
                  dec_instr_o.branch_speculation);
        check_decoded("dec_instr_o", exp_q.pop_front(), dec_instr_o);
        accepted++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Reset, then run until the queue drains and eight more cycles pass
  task automatic run_program(input string name, input logic use_bp, input int mp_after);
    int   cycles;
    int   tail;
    int   errors_before;
    logic pulsed;
    errors_before = errors;
    accepted      = 0;
    cycles        = 0;
    tail          = 0;
    pulsed        = 1'b0;
    rst_n_i <= 1'b0;
    ready_i <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    while (cycles < MAX_CYCLES && tail < 8) begin
      @(posedge clk_i);
      ready_i             <= use_bp ? (lfsr_step() | lfsr_step()) : 1'b1;
      mis_predict_i       <= (accepted == mp_after) && !pulsed;
      branch_mis_target_i <= 16'h0040;
      pulsed = pulsed || (accepted == mp_after);
      cycles++;
      if (exp_q.size() == 0) begin
        tail++;
      end
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected outputs never appeared", name, exp_q.size());
      errors++;
    end
    if (errors == errors_before) begin
      passes++;
      $display("Test %s passed", name);
    end else begin
      fails++;
      $display("Test %s failed", name);
    end
  endtask

  task automatic test_straight_line();
    prepare(STRAIGHT, 64);
    run_program("straight-line decode", 1'b0, -1);
  endtask

  task automatic test_dropping();
    prepare(DROPS, 64);
    run_program("dropping", 1'b0, -1);
  endtask

  task automatic test_unconditional_branch();
    prepare(UNCOND, 64);
    run_program("unconditional branch", 1'b0, -1);
  endtask

  task automatic test_conditional_branch();
    prepare(COND, 64);
    run_program("conditional branch", 1'b0, -1);
  endtask

  task automatic test_back_pressure();
    prepare(STRAIGHT, 64);
    run_program("back-pressure", 1'b1, -1);
  endtask

  // Pulse after three outputs; the fourth is shown in the pulse cycle
  task automatic test_mis_predict();
    prepare(STRAIGHT, 4);
    load_program(16'h0040, STRAIGHT);
    walk(16'h0040, 16'h004C, 64);
    run_program("mis-predict", 1'b0, 3);
  endtask

  initial begin
    rst_n_i             = 1'b0;
    ready_i             = 1'b0;
    mis_predict_i       = 1'b0;
    branch_mis_target_i = '0;
    lfsr                = 32'he992_7f89;
    errors              = 0;
    passes              = 0;
    fails               = 0;
    accepted            = 0;
    test_straight_line();
    test_dropping();
    test_unconditional_branch();
    test_conditional_branch();
    test_back_pressure();
    test_mis_predict();
    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d", passes, fails,
             u_fe_top.u_fe_chk.violations);
    if (fails == 0 && u_fe_top.u_fe_chk.violations == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== fe_top.f ====
hdl/fe_pkg.sv
hdl/fetch_unit.sv
hdl/pipe_stage.sv
hdl/decoder.sv
hdl/branch_unit.sv
hdl/fe_top.sv
testbench/fe_chk.sv
testbench/fe_tb.sv
